//--- build.f
+incdir+tb
hdl/rv32i_types.sv
hdl/ir.sv
hdl/control_rom.sv
hdl/regfile.sv
hdl/decode.sv
tb/decode_clock_gen.sv
tb/tb_decode.sv

//--- tb/decode_model.svh
`ifndef decode_model_svh
`define decode_model_svh

rv32i_types::rv32i_word shadow [rv32i_types::num_regs];   // mirror of the register file

function automatic void clear_shadow();
    for (int k = 0; k < rv32i_types::num_regs; k++) begin
        shadow[k] = '0;
    end
endfunction

function automatic void shadow_write(input rv32i_types::rv32i_reg r,
                                     input rv32i_types::rv32i_word d);
    if (r != 5'd0) begin
        shadow[r] = d;                          // x0 stays zero
    end
endfunction

// sign bit sits at width-1 of v
function automatic rv32i_types::rv32i_word sign_ext(input logic [31:0] v, input int width);
    return $signed(v << (32 - width)) >>> (32 - width);
endfunction

function automatic rv32i_types::rv32i_control_word model_ctrl(input rv32i_types::rv32i_word w);
    rv32i_types::rv32i_control_word c;
    logic [2:0] f3;
    logic       is_reg;
    f3       = w[14:12];
    is_reg   = (w[6:0] == rv32i_types::op_reg);
    c        = '0;                              // add, rs1, alu_out, no enables
    c.opcode = rv32i_types::rv32i_opcode'(w[6:0]);
    case (w[6:0])
        rv32i_types::op_lui: begin
            c.load_regfile   = 1'b1;
            c.regfilemux_sel = rv32i_types::rf_u_imm;
        end
        rv32i_types::op_auipc: begin
            c.load_regfile = 1'b1;
            c.alumux1_sel  = rv32i_types::alumux1_pc;
            c.alumux2_sel  = rv32i_types::alumux2_u_imm;
        end
        rv32i_types::op_jal, rv32i_types::op_jalr: begin
            c.load_regfile   = 1'b1;
            c.regfilemux_sel = rv32i_types::rf_pc_plus4;   // link value
            if (w[6:0] == rv32i_types::op_jal) begin
                c.alumux1_sel = rv32i_types::alumux1_pc;
                c.alumux2_sel = rv32i_types::alumux2_j_imm;
            end
        end
        rv32i_types::op_br: begin
            c.alumux1_sel = rv32i_types::alumux1_pc;
            c.alumux2_sel = rv32i_types::alumux2_b_imm;
            c.cmpop       = rv32i_types::branch_funct3'(f3);
        end
        rv32i_types::op_load: begin
            c.load_regfile    = 1'b1;
            c.mem_read        = 1'b1;
            c.mem_byte_enable = f3[1] ? 4'b1111 : (f3[0] ? 4'b0011 : 4'b0001);
            case (f3)
                3'b000:  c.regfilemux_sel = rv32i_types::rf_lb;
                3'b001:  c.regfilemux_sel = rv32i_types::rf_lh;
                3'b100:  c.regfilemux_sel = rv32i_types::rf_lbu;
                3'b101:  c.regfilemux_sel = rv32i_types::rf_lhu;
                default: c.regfilemux_sel = rv32i_types::rf_lw;   // lw and reserved
            endcase
        end
        rv32i_types::op_store: begin
            c.mem_write       = 1'b1;
            c.alumux2_sel     = rv32i_types::alumux2_s_imm;
            c.mem_byte_enable = (f3 == 3'b000) ? 4'b0001 : ((f3 == 3'b001) ? 4'b0011 : 4'b1111);
        end
        rv32i_types::op_imm, rv32i_types::op_reg: begin
            c.load_regfile = 1'b1;
            c.alumux2_sel  = is_reg ? rv32i_types::alumux2_rs2 : rv32i_types::alumux2_i_imm;
            c.cmpmux_sel   = is_reg ? rv32i_types::cmpmux_rs2 : rv32i_types::cmpmux_i_imm;
            case (f3)
                3'b000: c.aluop = (is_reg && w[30]) ? rv32i_types::alu_sub : rv32i_types::alu_add;
                3'b001: c.aluop = rv32i_types::alu_sll;
                3'b010: begin
                    c.cmpop          = rv32i_types::blt;       // slt
                    c.regfilemux_sel = rv32i_types::rf_br_en;
                end
                3'b011: begin
                    c.cmpop          = rv32i_types::bltu;      // sltu
                    c.regfilemux_sel = rv32i_types::rf_br_en;
                end
                3'b100: c.aluop = rv32i_types::alu_xor;
                3'b101: c.aluop = w[30] ? rv32i_types::alu_sra : rv32i_types::alu_srl;
                3'b110: c.aluop = rv32i_types::alu_or;
                default: c.aluop = rv32i_types::alu_and;
            endcase
        end
        default: ;                              // csr, unknown
    endcase
    return c;
endfunction

function automatic rv32i_types::stage_regs model_stage(input rv32i_types::rv32i_word w,
                                                       input rv32i_types::rv32i_word pcv);
    rv32i_types::stage_regs s;
    s        = '0;
    s.pc     = pcv;
    s.i_imm  = sign_ext(w[31:20], 12);
    s.s_imm  = sign_ext({w[31:25], w[11:7]}, 12);
    s.b_imm  = sign_ext({w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
    s.u_imm  = {w[31:12], 12'h000};
    s.j_imm  = sign_ext({w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
    s.rs1    = shadow[w[19:15]];                // old value on a same-cycle write
    s.rs2    = shadow[w[24:20]];
    s.rd     = w[11:7];
    s.funct3 = w[14:12];
    s.ctrl   = model_ctrl(w);
    s.valid  = 1'b1;
    return s;
endfunction

`endif

//--- tb/tb_decode.sv
`timescale 1ns/100ps

module tb_decode;

    logic                   clk;
    logic                   rst_n;
    rv32i_types::rv32i_word rdata_a;
    rv32i_types::rv32i_word pc;
    logic                   resp_a;
    logic                   resp_b;
    rv32i_types::rv32i_word cache_out;
    logic                   ld_regfile;
    rv32i_types::rv32i_reg  rd;
    rv32i_types::stage_regs regs_out;

    rv32i_types::stage_regs exp_out = '0;       // expected stage register
    logic pending = 1'b0;                       // a load is due at the next check
    int stage_errs = 0;
    int ctrl_errs = 0;
    int word_errs = 0;
    int timeouts = 0;
    int loads_sent = 0;
    int loads_checked = 0;

    `include "decode_model.svh"

    decode_clock_gen u_clk (.clk(clk));

    decode uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .rdata_a    (rdata_a),
        .pc         (pc),
        .resp_a     (resp_a),
        .resp_b     (resp_b),
        .cache_out  (cache_out),
        .ld_regfile (ld_regfile),
        .rd         (rd),
        .regs_out   (regs_out)
    );

    task automatic compare_word(input rv32i_types::rv32i_word act,
                                input rv32i_types::rv32i_word exp, input string what);
        if (act !== exp) begin
            word_errs++;
            $display("error %0t: %s expected %h got %h", $time, what, exp, act);
        end
    endtask

    task automatic compare_ctrl(input rv32i_types::rv32i_control_word act,
                                input rv32i_types::rv32i_control_word exp);
        if (act !== exp) begin
            ctrl_errs++;
            $display("error %0t: ctrl expected %h got %h", $time, exp, act);
        end
    endtask

    task automatic compare_stage(input rv32i_types::stage_regs act,
                                 input rv32i_types::stage_regs exp);
        compare_word(act.pc, exp.pc, "pc");
        compare_word(act.i_imm, exp.i_imm, "i_imm");
        compare_word(act.s_imm, exp.s_imm, "s_imm");
        compare_word(act.b_imm, exp.b_imm, "b_imm");
        compare_word(act.u_imm, exp.u_imm, "u_imm");
        compare_word(act.j_imm, exp.j_imm, "j_imm");
        compare_word(act.rs1, exp.rs1, "rs1 value");
        compare_word(act.rs2, exp.rs2, "rs2 value");
        compare_ctrl(act.ctrl, exp.ctrl);
        if ({act.rd, act.funct3, act.valid} !== {exp.rd, exp.funct3, exp.valid}) begin
            stage_errs++;
            $display("error %0t: rd/funct3/valid expected %h/%h/%b got %h/%h/%b", $time,
                     exp.rd, exp.funct3, exp.valid, act.rd, act.funct3, act.valid);
        end
    endtask

    // checks at negedge, inputs and regs_out are settled there
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            compare_stage(regs_out, exp_out);   // compared once out of reset
        end
        if (pending) begin
            loads_checked++;
        end
        if (rst_n !== 1'b1) begin
            exp_out = '0;
            pending = 1'b0;
            clear_shadow();
        end else begin
            pending = resp_a | resp_b;
            if (pending) begin
                exp_out = model_stage(rdata_a, pc);  // reads before this cycle's write
            end
            if (ld_regfile) begin
                shadow_write(rd, cache_out);
            end
        end
    end

    task automatic drive_cycle(input rv32i_types::rv32i_word instr, input logic ra,
                               input logic rb, input logic ld, input rv32i_types::rv32i_reg wrd,
                               input rv32i_types::rv32i_word wdata);
        @(posedge clk);
        rdata_a    <= instr;
        pc         <= $urandom();
        resp_a     <= ra;
        resp_b     <= rb;
        ld_regfile <= ld;
        rd         <= wrd;
        cache_out  <= wdata;
        if (ra | rb) begin
            loads_sent++;
        end
    endtask

    function automatic rv32i_types::rv32i_word reg_instr(input rv32i_types::rv32i_reg r1,
                                                         input rv32i_types::rv32i_reg r2,
                                                         input rv32i_types::rv32i_reg rdest);
        return {7'b0000000, r2, r1, 3'b000, rdest, rv32i_types::op_reg};   // add
    endfunction

    task automatic finish_run();
        $display("summary: %0d loads, %0d stage, %0d ctrl, %0d word errors, %0d timeouts",
                 loads_checked, stage_errs, ctrl_errs, word_errs, timeouts);
        if (stage_errs + ctrl_errs + word_errs + timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    initial begin
        rv32i_types::rv32i_word instr;
        logic [6:0]             ops [12];
        logic [6:0]             f7;
        int                     waited;
        void'($urandom(7));                     // single seed for the run
        ops = '{rv32i_types::op_lui, rv32i_types::op_auipc, rv32i_types::op_jal,
                rv32i_types::op_jalr, rv32i_types::op_br, rv32i_types::op_load,
                rv32i_types::op_store, rv32i_types::op_imm, rv32i_types::op_reg,
                rv32i_types::op_csr, 7'b0000000, 7'b1111111};   // last two unknown
        rst_n      = 1'b0;
        rdata_a    = '0;
        pc         = '0;
        resp_a     = 1'b0;
        resp_b     = 1'b0;
        cache_out  = '0;
        ld_regfile = 1'b0;
        rd         = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // every register reads zero after reset
        for (int k = 0; k < 16; k++) begin
            drive_cycle(reg_instr(5'(k), 5'(31 - k), 5'(k)), 1'b1, 1'b0, 1'b0, '0, '0);
        end
        // random writebacks under op_reg decodes
        for (int k = 0; k < 60; k++) begin
            drive_cycle(reg_instr(5'($urandom()), 5'($urandom()), 5'($urandom())), 1'b1,
                        1'b0, ($urandom() % 4) != 0, 5'($urandom()), $urandom());
        end
        drive_cycle(reg_instr(5'd7, 5'd7, 5'd1), 1'b1, 1'b0, 1'b1, 5'd7, 32'hdeadbeef);
        drive_cycle(reg_instr(5'd7, 5'd0, 5'd1), 1'b1, 1'b0, 1'b1, 5'd0, 32'hffffffff);
        drive_cycle(reg_instr(5'd0, 5'd7, 5'd2), 1'b0, 1'b1, 1'b0, '0, '0);

        // random words of every opcode, random strobes including hold cycles
        for (int k = 0; k < 240; k++) begin
            instr      = $urandom();
            instr[6:0] = ops[$urandom() % 12];
            drive_cycle(instr, 1'($urandom()), 1'($urandom()), 1'($urandom()),
                        5'($urandom()), $urandom());
        end

        // control word sweep
        for (int o = 0; o < 12; o++) begin
            for (int f = 0; f < 8; f++) begin
                for (int v = 0; v < 3; v++) begin
                    f7           = (v == 0) ? 7'h00 : ((v == 1) ? 7'h20 : 7'($urandom()));
                    instr        = $urandom();
                    instr[6:0]   = ops[o];
                    instr[14:12] = 3'(f);
                    instr[31:25] = f7;
                    drive_cycle(instr, 1'b1, 1'b0, 1'b0, '0, '0);
                end
            end
        end

        // hold with both strobes low, then each strobe alone
        for (int k = 0; k < 6; k++) begin
            drive_cycle($urandom(), 1'b0, 1'b0, 1'b0, '0, '0);
        end
        drive_cycle($urandom(), 1'b1, 1'b0, 1'b0, '0, '0);
        drive_cycle($urandom(), 1'b0, 1'b0, 1'b0, '0, '0);
        drive_cycle($urandom(), 1'b0, 1'b1, 1'b0, '0, '0);
        drive_cycle($urandom(), 1'b0, 1'b0, 1'b0, '0, '0);

        waited = 0;
        while (loads_checked < loads_sent && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (loads_checked < loads_sent) begin
            timeouts++;
            $display("timed out waiting for checks, only %0d of %0d loads were compared",
                     loads_checked, loads_sent);
        end
        finish_run();
    end

endmodule : tb_decode

//--- tb/decode_clock_gen.sv
`timescale 1ns/100ps

module decode_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;                     // 40 ns period
        end
    end

endmodule : decode_clock_gen

//--- hdl/decode.sv
`timescale 1ns/100ps

module decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv32i_types::rv32i_word rdata_a,     // instruction word from fetch
    input  rv32i_types::rv32i_word pc,          // pc of that instruction
    input  logic                   resp_a,      // imem response
    input  logic                   resp_b,      // dmem response
    input  rv32i_types::rv32i_word cache_out,   // writeback data
    input  logic                   ld_regfile,  // writeback enable
    input  rv32i_types::rv32i_reg  rd,          // writeback destination
    output rv32i_types::stage_regs regs_out     // to execute
);

    logic                           load_all;
    rv32i_types::rv32i_word         i_imm;
    rv32i_types::rv32i_word         s_imm;
    rv32i_types::rv32i_word         b_imm;
    rv32i_types::rv32i_word         u_imm;
    rv32i_types::rv32i_word         j_imm;
    rv32i_types::rv32i_reg          reg_rd;      // rd of the decoded instruction
    rv32i_types::rv32i_reg          src_a;
    rv32i_types::rv32i_reg          src_b;
    rv32i_types::rv32i_word         reg_a;
    rv32i_types::rv32i_word         reg_b;
    rv32i_types::rv32i_control_word ctrl;
    rv32i_types::rv32i_opcode       ir_op;
    logic [2:0]                     funct3;
    logic [6:0]                     funct7;
    rv32i_types::stage_regs         stage;       // next value of the stage register

    assign load_all = resp_a | resp_b;           // either strobe advances the stage

    ir u_ir (
        .in     (rdata_a),
        .funct3 (funct3),                        // to rom and stage
        .funct7 (funct7),                        // rom only
        .opcode (ir_op),
        .i_imm  (i_imm),
        .s_imm  (s_imm),
        .b_imm  (b_imm),
        .u_imm  (u_imm),
        .j_imm  (j_imm),
        .rs1    (src_a),                         // regfile read ports
        .rs2    (src_b),
        .rd     (reg_rd)
    );

    control_rom u_rom (
        .opcode (ir_op),
        .funct3 (funct3),
        .funct7 (funct7),
        .ctrl   (ctrl)
    );

    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (ld_regfile),                     // driven from writeback
        .in    (cache_out),
        .src_a (src_a),
        .src_b (src_b),
        .dest  (rd),                             // writeback rd, not ours
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    always_comb begin
        stage        = '0;
        stage.pc     = pc;
        stage.i_imm  = i_imm;
        stage.s_imm  = s_imm;
        stage.b_imm  = b_imm;
        stage.u_imm  = u_imm;
        stage.j_imm  = j_imm;
        stage.rs1    = reg_a;                    // operand values
        stage.rs2    = reg_b;
        stage.rd     = reg_rd;
        stage.funct3 = funct3;
        stage.ctrl   = ctrl;
        stage.valid  = 1'b1;                     // anything captured is live
    end

    // stage register, holds while both strobes are low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs_out <= '0;                      // valid and enables inactive
        end else if (load_all) begin
            regs_out <= stage;
        end
    end

endmodule : decode

//--- hdl/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load,        // writeback strobe
    input  rv32i_types::rv32i_word in,          // writeback data
    input  rv32i_types::rv32i_reg  src_a,
    input  rv32i_types::rv32i_reg  src_b,
    input  rv32i_types::rv32i_reg  dest,
    output rv32i_types::rv32i_word reg_a,
    output rv32i_types::rv32i_word reg_b
);

    rv32i_types::rv32i_word data [rv32i_types::num_regs];

    // x0 never written, so it stays at its reset zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < rv32i_types::num_regs; k++) begin
                data[k] <= '0;                  // whole file cleared
            end
        end else if (load && (dest != '0)) begin
            data[dest] <= in;
        end
    end

    // plain lookup, same-cycle write shows up next cycle
    assign reg_a = data[src_a];
    assign reg_b = data[src_b];

endmodule : regfile

//--- hdl/control_rom.sv
`timescale 1ns/100ps

module control_rom (
    input  rv32i_types::rv32i_opcode        opcode,
    input  logic [2:0]                      funct3,
    input  logic [6:0]                      funct7,
    output rv32i_types::rv32i_control_word  ctrl
);

    always_comb begin
        ctrl        = '0;                               // nothing enabled by default
        ctrl.opcode = opcode;                           // passed along to execute

        case (opcode)
            rv32i_types::op_lui: begin
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = rv32i_types::rf_u_imm;
            end

            rv32i_types::op_auipc: begin
                ctrl.aluop          = rv32i_types::alu_add;
                ctrl.alumux1_sel    = rv32i_types::alumux1_pc;
                ctrl.alumux2_sel    = rv32i_types::alumux2_u_imm;
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = rv32i_types::rf_alu_out;
            end

            rv32i_types::op_jal: begin
                ctrl.aluop          = rv32i_types::alu_add;    // target = pc + j
                ctrl.alumux1_sel    = rv32i_types::alumux1_pc;
                ctrl.alumux2_sel    = rv32i_types::alumux2_j_imm;
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = rv32i_types::rf_pc_plus4;  // link
            end

            rv32i_types::op_jalr: begin
                ctrl.aluop          = rv32i_types::alu_add;    // target = rs1 + i
                ctrl.alumux1_sel    = rv32i_types::alumux1_rs1;
                ctrl.alumux2_sel    = rv32i_types::alumux2_i_imm;
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = rv32i_types::rf_pc_plus4;
            end

            rv32i_types::op_br: begin
                ctrl.aluop       = rv32i_types::alu_add;       // target = pc + b
                ctrl.alumux1_sel = rv32i_types::alumux1_pc;
                ctrl.alumux2_sel = rv32i_types::alumux2_b_imm;
                ctrl.cmpop       = rv32i_types::branch_funct3'(funct3);
                ctrl.cmpmux_sel  = rv32i_types::cmpmux_rs2;
            end

            rv32i_types::op_load: begin
                ctrl.aluop        = rv32i_types::alu_add;      // address = rs1 + i
                ctrl.alumux2_sel  = rv32i_types::alumux2_i_imm;
                ctrl.mem_read     = 1'b1;
                ctrl.load_regfile = 1'b1;
                case (rv32i_types::load_funct3'(funct3))
                    rv32i_types::f3_lb: begin
                        ctrl.regfilemux_sel  = rv32i_types::rf_lb;
                        ctrl.mem_byte_enable = 4'b0001;
                    end
                    rv32i_types::f3_lbu: begin
                        ctrl.regfilemux_sel  = rv32i_types::rf_lbu;
                        ctrl.mem_byte_enable = 4'b0001;
                    end
                    rv32i_types::f3_lh: begin
                        ctrl.regfilemux_sel  = rv32i_types::rf_lh;
                        ctrl.mem_byte_enable = 4'b0011;
                    end
                    rv32i_types::f3_lhu: begin
                        ctrl.regfilemux_sel  = rv32i_types::rf_lhu;
                        ctrl.mem_byte_enable = 4'b0011;
                    end
                    default: begin                              // lw and reserved codes
                        ctrl.regfilemux_sel  = rv32i_types::rf_lw;
                        ctrl.mem_byte_enable = 4'b1111;
                    end
                endcase
            end

            rv32i_types::op_store: begin
                ctrl.aluop       = rv32i_types::alu_add;       // address = rs1 + s
                ctrl.alumux2_sel = rv32i_types::alumux2_s_imm;
                ctrl.mem_write   = 1'b1;
                case (rv32i_types::store_funct3'(funct3))
                    rv32i_types::f3_sb: ctrl.mem_byte_enable = 4'b0001;
                    rv32i_types::f3_sh: ctrl.mem_byte_enable = 4'b0011;
                    default:            ctrl.mem_byte_enable = 4'b1111;
                endcase
            end

            rv32i_types::op_imm, rv32i_types::op_reg: begin
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = rv32i_types::rf_alu_out;
                ctrl.alumux2_sel    = (opcode == rv32i_types::op_reg) ?
                                      rv32i_types::alumux2_rs2 :
                                      rv32i_types::alumux2_i_imm;
                ctrl.cmpmux_sel     = (opcode == rv32i_types::op_reg) ?
                                      rv32i_types::cmpmux_rs2 :
                                      rv32i_types::cmpmux_i_imm;
                case (rv32i_types::arith_funct3'(funct3))
                    rv32i_types::f3_add: begin
                        // sub only exists in the register form
                        ctrl.aluop = (opcode == rv32i_types::op_reg && funct7[5]) ?
                                     rv32i_types::alu_sub : rv32i_types::alu_add;
                    end
                    rv32i_types::f3_sr: begin
                        ctrl.aluop = funct7[5] ? rv32i_types::alu_sra :
                                                 rv32i_types::alu_srl;
                    end
                    rv32i_types::f3_slt: begin
                        ctrl.cmpop          = rv32i_types::blt;  // compare path
                        ctrl.regfilemux_sel = rv32i_types::rf_br_en;
                    end
                    rv32i_types::f3_sltu: begin
                        ctrl.cmpop          = rv32i_types::bltu;
                        ctrl.regfilemux_sel = rv32i_types::rf_br_en;
                    end
                    default: ctrl.aluop = rv32i_types::alu_ops'(funct3);  // same encoding
                endcase
            end

            default: ;                                  // csr and unknown: no enables
        endcase
    end

endmodule : control_rom

//--- hdl/ir.sv
`timescale 1ns/100ps

module ir (
    input  rv32i_types::rv32i_word   in,        // raw instruction from fetch
    output logic [2:0]               funct3,
    output logic [6:0]               funct7,
    output rv32i_types::rv32i_opcode opcode,
    output rv32i_types::rv32i_word   i_imm,
    output rv32i_types::rv32i_word   s_imm,
    output rv32i_types::rv32i_word   b_imm,
    output rv32i_types::rv32i_word   u_imm,
    output rv32i_types::rv32i_word   j_imm,
    output rv32i_types::rv32i_reg    rs1,
    output rv32i_types::rv32i_reg    rs2,
    output rv32i_types::rv32i_reg    rd
);

    // fixed field positions
    assign opcode = rv32i_types::rv32i_opcode'(in[6:0]);   // unknown codes pass as-is
    assign rd     = in[11:7];
    assign funct3 = in[14:12];
    assign rs1    = in[19:15];
    assign rs2    = in[24:20];
    assign funct7 = in[31:25];

    // I type, imm[11:0] in [31:20]
    assign i_imm = {{21{in[31]}}, in[30:20]};

    // S type, split around rd slot
    assign s_imm = {{21{in[31]}}, in[30:25], in[11:7]};

    // B type, bit 11 sits at in[7], lsb implied zero
    assign b_imm = {
        {20{in[31]}},                           // sign
        in[7],                                  // imm[11]
        in[30:25],                              // imm[10:5]
        in[11:8],                               // imm[4:1]
        1'b0
    };

    // U type, upper 20 bits
    assign u_imm = {in[31:12], 12'h000};

    // J type, the odd one
    assign j_imm = {
        {12{in[31]}},                           // sign
        in[19:12],                              // imm[19:12]
        in[20],                                 // imm[11]
        in[30:21],                              // imm[10:1]
        1'b0
    };

endmodule : ir

//--- hdl/rv32i_types.sv
package rv32i_types;

    localparam int num_regs = 32;                   // x0..x31

    typedef logic [31:0] rv32i_word;                // data or instruction word
    typedef logic [4:0]  rv32i_reg;                 // register index

    // base opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011                       // decoded but not executed
    } rv32i_opcode;

    // encoding lines up with arith funct3 except sra/sub
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3;

    typedef enum logic [2:0] {
        f3_add  = 3'b000,                           // also sub via funct7
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_sr   = 3'b101,                           // srl / sra via funct7
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } arith_funct3;

    typedef enum logic [2:0] {
        f3_lb  = 3'b000,
        f3_lh  = 3'b001,
        f3_lw  = 3'b010,
        f3_lbu = 3'b100,
        f3_lhu = 3'b101
    } load_funct3;

    typedef enum logic [2:0] {
        f3_sb = 3'b000,
        f3_sh = 3'b001,
        f3_sw = 3'b010
    } store_funct3;

    typedef enum logic {
        alumux1_rs1 = 1'b0,
        alumux1_pc  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm = 3'd0,
        alumux2_u_imm = 3'd1,
        alumux2_b_imm = 3'd2,
        alumux2_s_imm = 3'd3,
        alumux2_j_imm = 3'd4,
        alumux2_rs2   = 3'd5
    } alumux2_sel_t;

    typedef enum logic [3:0] {
        rf_alu_out  = 4'd0,
        rf_br_en    = 4'd1,                         // slt/sltu result
        rf_u_imm    = 4'd2,
        rf_lw       = 4'd3,
        rf_pc_plus4 = 4'd4,
        rf_lb       = 4'd5,
        rf_lbu      = 4'd6,
        rf_lh       = 4'd7,
        rf_lhu      = 4'd8
    } regfilemux_sel_t;

    typedef enum logic {
        cmpmux_rs2   = 1'b0,
        cmpmux_i_imm = 1'b1
    } cmpmux_sel_t;

    typedef struct packed {
        rv32i_opcode     opcode;
        alu_ops          aluop;
        branch_funct3    cmpop;
        alumux1_sel_t    alumux1_sel;
        alumux2_sel_t    alumux2_sel;
        regfilemux_sel_t regfilemux_sel;
        cmpmux_sel_t     cmpmux_sel;
        logic            load_regfile;
        logic            mem_read;
        logic            mem_write;
        logic [3:0]      mem_byte_enable;           // unshifted, low lanes
    } rv32i_control_word;

    typedef struct packed {
        rv32i_word         pc;
        rv32i_word         i_imm;
        rv32i_word         s_imm;
        rv32i_word         b_imm;
        rv32i_word         u_imm;
        rv32i_word         j_imm;
        rv32i_word         rs1;                     // register values, not indexes
        rv32i_word         rs2;
        rv32i_reg          rd;
        logic [2:0]        funct3;
        rv32i_control_word ctrl;
        logic              valid;
    } stage_regs;

endpackage : rv32i_types
